// File: project.f
rtl/param_defs.sv
rtl/instr_defs.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/reg_file.sv
rtl/ex_stage.sv
rtl/mem_stage.sv
rtl/riscv_core.sv
sim/tb_riscv_core.sv

// File: sim/core_stim.txt
// word 0 is the instruction count, then one word per instruction
// then the store count, then one address/data pair per expected store in order
0000002a            // 42 instructions
00500093 00c00113   // addi x1,x0,5  addi x2,x0,12
123451b7 ffd00213   // lui x3,0x12345  addi x4,x0,-3
002082b3 40208333   // add x5,x1,x2  sub x6,x1,x2
0020f3b3 0020e433   // and x7,x1,x2  or x8,x1,x2
0020c4b3 00122533   // xor x9,x1,x2  slt x10,x4,x1
10502023 10602223   // sw x5,0x100(x0)  sw x6,0x104(x0)
10702423 10802623   // sw x7,0x108(x0)  sw x8,0x10c(x0)
10902823 10a02a23   // sw x9,0x110(x0)  sw x10,0x114(x0)
10302c23            // sw x3,0x118(x0)
10002583 00700013   // lw x11,0x100(x0)  addi x0,x0,7
00000013 06458613   // nop  addi x12,x11,100
10002e23 00000013   // sw x0,0x11c(x0)  nop
12c02023 12002683   // sw x12,0x120(x0)  lw x13,0x120(x0)
00000013 00000013   // nop  nop
40168733 00000013   // sub x14,x13,x1  nop
00000013 12e02223   // nop  sw x14,0x124(x0)
00108663            // beq x1,x1,+12 taken
20102023 20202223   // sw x1,0x200(x0)  sw x2,0x204(x0) flushed
00209663            // bne x1,x2,+12 taken
20102423 20202623   // sw x1,0x208(x0)  sw x2,0x20c(x0) flushed
00208663            // beq x1,x2,+12 not taken
12102423 12202623   // sw x1,0x128(x0)  sw x2,0x12c(x0)
00109663 12702823   // bne x1,x1,+12 not taken  sw x7,0x130(x0)
0000000d            // 13 stores
00000100 00000011   // 5 + 12
00000104 fffffff9   // 5 - 12
00000108 00000004   // 5 and 12
0000010c 0000000d   // 5 or 12
00000110 00000009   // 5 xor 12
00000114 00000001   // -3 < 5
00000118 12345000   // lui
0000011c 00000000   // x0 stays zero
00000120 00000075   // loaded 17 + 100
00000124 00000070   // reloaded 117 - 5
00000128 00000005
0000012c 0000000c
00000130 00000004

// File: sim/tb_riscv_core.sv
// tb_riscv_core
// runs the stim program on riscv_core under random mem_ready stalls and
// compares every accepted store with the expected store list
`timescale 1ns/1ns

module tb_riscv_core;

  import param_defs::*;

  localparam addr_t  ResetPc   = 32'h0000_0080;
  localparam int     MaxProg   = 128;
  localparam int     MaxStores = 32;
  localparam instr_t NopWord   = 32'h0000_0013;  // addi x0,x0,0

  logic        clk;
  logic        arst_n;
  logic        mem_ready;
  instr_t      imem_rd_data;
  data_t       dmem_rd_data;
  addr_t       imem_addr;
  addr_t       dmem_addr;
  data_t       dmem_wr_data;
  logic        dmem_wr_en;
  logic        dmem_rd_en;

  logic [31:0] stim_mem [0:255];
  instr_t      imem [0:MaxProg-1];
  data_t       dmem [0:255];
  addr_t       exp_addr [0:MaxStores-1];
  data_t       exp_data [0:MaxStores-1];
  logic [31:0] fetch_idx;
  int unsigned prog_len = 0;
  int unsigned exp_count = 0;
  int unsigned store_idx = 0;
  bit          stim_ok = 1'b0;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count;
  int          cycle_limit;
  integer      seed;

  riscv_core #(
    .RESET_PC(ResetPc)
  ) dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .imem_rd_data(imem_rd_data),
    .dmem_rd_data(dmem_rd_data),
    .mem_ready   (mem_ready),
    .imem_addr   (imem_addr),
    .dmem_addr   (dmem_addr),
    .dmem_wr_data(dmem_wr_data),
    .dmem_wr_en  (dmem_wr_en),
    .dmem_rd_en  (dmem_rd_en)
  );

  // both memories answer in the same cycle
  assign fetch_idx    = (imem_addr - ResetPc) >> 2;
  assign imem_rd_data = (fetch_idx < prog_len) ? imem[fetch_idx] : NopWord;  // nop past the end
  assign dmem_rd_data = dmem_rd_en ? dmem[dmem_addr[9:2]] : 'x;  // data only for a strobed load

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // data memory write and store stream check on accepted cycles only
  always @(posedge clk) begin
    if (arst_n && mem_ready && dmem_wr_en) begin
      dmem[dmem_addr[9:2]] <= dmem_wr_data;
      check_count++;
      assert (store_idx < exp_count) else begin
        error_count++;
        $display("unexpected store after all %0d expected ones at %0t: %h to address %h",
                 exp_count, $time, dmem_wr_data, dmem_addr);
      end
      if (store_idx < exp_count) begin
        assert (dmem_addr === exp_addr[store_idx] && dmem_wr_data === exp_data[store_idx])
        else begin
          error_count++;
          $display("[FAIL] %0t store %0d wrote %h to %h, expected %h to %h", $time,
                   store_idx, dmem_wr_data, dmem_addr, exp_data[store_idx],
                   exp_addr[store_idx]);
        end
      end
      store_idx++;
    end
  end

  // no memory strobes and the fetch address parked at the reset pc
  task automatic check_idle(input string phase);
    check_count++;
    assert (dmem_wr_en === 1'b0 && dmem_rd_en === 1'b0 && imem_addr === ResetPc) else begin
      error_count++;
      $display("[FAIL] %0t %s wr_en %b rd_en %b imem_addr %h, expected idle at %h",
               $time, phase, dmem_wr_en, dmem_rd_en, imem_addr, ResetPc);
    end
  endtask

  task automatic load_stim();
    $readmemh("sim/core_stim.txt", stim_mem);
    prog_len = stim_mem[0];
    check_count++;
    assert (prog_len > 0 && prog_len <= MaxProg) else begin
      error_count++;
      $display("stim file gives a program length of %0d words, out of range", prog_len);
    end
    if (prog_len > 0 && prog_len <= MaxProg) begin
      for (int i = 0; i < prog_len; i++) begin
        imem[i] = stim_mem[1 + i];
      end
      exp_count = stim_mem[prog_len + 1];
      check_count++;
      assert (exp_count <= MaxStores) else begin
        error_count++;
        $display("stim file lists %0d stores, more than the testbench holds", exp_count);
      end
      stim_ok = (exp_count <= MaxStores);
      for (int k = 0; k < exp_count && k < MaxStores; k++) begin
        exp_addr[k] = stim_mem[prog_len + 2 + 2 * k];
        exp_data[k] = stim_mem[prog_len + 3 + 2 * k];
      end
    end
  endtask

  initial begin
    addr_t end_pc;
    seed      = 32'hb49ea0b2;
    arst_n    = 1'b0;
    mem_ready = 1'b1;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'ha5a5_0000 + (i << 2);  // each word holds its own byte address
    end
    load_stim();

    repeat (3) begin
      @(posedge clk);
      #1;
      check_idle("in reset");
    end
    arst_n = 1'b1;
    check_idle("after reset release");

    cycle_count = 0;
    cycle_limit = 12 * prog_len + 100;
    end_pc      = ResetPc + 4 * (prog_len + 4);  // last instruction past writeback
    if (stim_ok) begin
      while (imem_addr < end_pc && cycle_count < cycle_limit) begin
        @(posedge clk);
        #1;
        cycle_count++;
        mem_ready = ($random(seed) & 7) != 0;  // about one stall cycle in eight
      end
      mem_ready = 1'b1;
      check_count++;
      assert (cycle_count < cycle_limit) else begin
        error_count++;
        $display("timeout after %0d cycles, expected stores did not all appear (%0d of %0d)",
                 cycle_count, store_idx, exp_count);
      end
      if (cycle_count < cycle_limit) begin
        check_count++;
        assert (store_idx == exp_count) else begin
          error_count++;
          $display("program finished with %0d stores, expected %0d", store_idx, exp_count);
        end
      end
    end

    $display("stores %0d of %0d, checks %0d, errors %0d, cycles %0d",
             store_idx, exp_count, check_count, error_count, cycle_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_riscv_core

// File: rtl/riscv_core.sv
// riscv_core
// five-stage in-order RV32I subset pipeline with split instruction/data ports
`timescale 1ns/1ns

module riscv_core #(
  parameter param_defs::addr_t RESET_PC = param_defs::DefaultResetPc
) (
  input  logic               clk,
  input  logic               arst_n,
  input  param_defs::instr_t imem_rd_data,
  input  param_defs::data_t  dmem_rd_data,
  input  logic               mem_ready,     // low freezes the whole pipe
  output param_defs::addr_t  imem_addr,
  output param_defs::addr_t  dmem_addr,
  output param_defs::data_t  dmem_wr_data,
  output logic               dmem_wr_en,
  output logic               dmem_rd_en
);

  import param_defs::*;
  import instr_defs::*;

  logic      stall;
  logic      br_taken;
  addr_t     br_target;
  addr_t     if_pc;
  instr_t    if_instr;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  data_t     rs1_data;
  data_t     rs2_data;
  addr_t     id_pc;
  data_t     id_imm;
  data_t     id_rs1_val;
  data_t     id_rs2_val;
  alu_op_e   id_alu_op;
  logic      id_use_imm;
  reg_addr_t id_rd;
  logic      id_rd_we;
  logic      id_is_load;
  logic      id_is_store;
  logic      id_is_branch;
  logic      id_br_ne;
  data_t     ex_result;
  data_t     ex_store_data;
  reg_addr_t ex_rd;
  logic      ex_rd_we;
  logic      ex_is_load;
  logic      ex_is_store;
  reg_addr_t wb_rd;
  data_t     wb_data;
  logic      wb_we;

  assign stall = !mem_ready;  // hold enable, clock keeps running

  if_stage #(
    .RESET_PC(RESET_PC)
  ) if_stage0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .stall       (stall),
    .flush       (br_taken),
    .br_target   (br_target),
    .imem_rd_data(imem_rd_data),
    .imem_addr   (imem_addr),
    .if_pc       (if_pc),
    .if_instr    (if_instr)
  );

  id_stage id_stage0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .stall       (stall),
    .flush       (br_taken),
    .if_pc       (if_pc),
    .if_instr    (if_instr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .id_pc       (id_pc),
    .id_imm      (id_imm),
    .id_rs1_val  (id_rs1_val),
    .id_rs2_val  (id_rs2_val),
    .id_alu_op   (id_alu_op),
    .id_use_imm  (id_use_imm),
    .id_rd       (id_rd),
    .id_rd_we    (id_rd_we),
    .id_is_load  (id_is_load),
    .id_is_store (id_is_store),
    .id_is_branch(id_is_branch),
    .id_br_ne    (id_br_ne)
  );

  reg_file reg_file0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .wb_we   (wb_we),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  ex_stage ex_stage0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .stall        (stall),
    .id_pc        (id_pc),
    .id_imm       (id_imm),
    .id_rs1_val   (id_rs1_val),
    .id_rs2_val   (id_rs2_val),
    .id_alu_op    (id_alu_op),
    .id_use_imm   (id_use_imm),
    .id_rd        (id_rd),
    .id_rd_we     (id_rd_we),
    .id_is_load   (id_is_load),
    .id_is_store  (id_is_store),
    .id_is_branch (id_is_branch),
    .id_br_ne     (id_br_ne),
    .br_taken     (br_taken),
    .br_target    (br_target),
    .ex_result    (ex_result),
    .ex_store_data(ex_store_data),
    .ex_rd        (ex_rd),
    .ex_rd_we     (ex_rd_we),
    .ex_is_load   (ex_is_load),
    .ex_is_store  (ex_is_store)
  );

  mem_stage mem_stage0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .stall        (stall),
    .ex_result    (ex_result),
    .ex_store_data(ex_store_data),
    .ex_rd        (ex_rd),
    .ex_rd_we     (ex_rd_we),
    .ex_is_load   (ex_is_load),
    .ex_is_store  (ex_is_store),
    .dmem_rd_data (dmem_rd_data),
    .dmem_addr    (dmem_addr),
    .dmem_wr_data (dmem_wr_data),
    .dmem_wr_en   (dmem_wr_en),
    .dmem_rd_en   (dmem_rd_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .wb_we        (wb_we)
  );

endmodule : riscv_core

// File: rtl/mem_stage.sv
// mem_stage
// drives the data port from EX/MEM and registers the writeback value
`timescale 1ns/1ns

module mem_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  stall,
  input  param_defs::data_t     ex_result,
  input  param_defs::data_t     ex_store_data,
  input  param_defs::reg_addr_t ex_rd,
  input  logic                  ex_rd_we,
  input  logic                  ex_is_load,
  input  logic                  ex_is_store,
  input  param_defs::data_t     dmem_rd_data,
  output param_defs::addr_t     dmem_addr,
  output param_defs::data_t     dmem_wr_data,
  output logic                  dmem_wr_en,
  output logic                  dmem_rd_en,
  output param_defs::reg_addr_t wb_rd,
  output param_defs::data_t     wb_data,
  output logic                  wb_we
);

  import param_defs::*;

  data_t wb_value;

  assign dmem_addr    = ex_result;
  assign dmem_wr_data = ex_store_data;
  assign dmem_wr_en   = ex_is_store;  // repeats while stalled
  assign dmem_rd_en   = ex_is_load;

  assign wb_value = ex_is_load ? dmem_rd_data : ex_result;

  // MEM/WB control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_rd <= '0;
      wb_we <= 1'b0;
    end else if (!stall) begin
      wb_rd <= ex_rd;
      wb_we <= ex_rd_we;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      wb_data <= wb_value;
    end
  end

  // only word stores exist, so the program must keep addresses aligned
  st_aligned_a : assert property (@(posedge clk) disable iff (!arst_n)
    dmem_wr_en |-> dmem_addr[1:0] == 2'b00);

endmodule : mem_stage

// File: rtl/ex_stage.sv
// ex_stage
// ALU, BEQ/BNE resolution and branch target, then the EX/MEM register
`timescale 1ns/1ns

module ex_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  stall,
  input  param_defs::addr_t     id_pc,
  input  param_defs::data_t     id_imm,
  input  param_defs::data_t     id_rs1_val,
  input  param_defs::data_t     id_rs2_val,
  input  instr_defs::alu_op_e   id_alu_op,
  input  logic                  id_use_imm,
  input  param_defs::reg_addr_t id_rd,
  input  logic                  id_rd_we,
  input  logic                  id_is_load,
  input  logic                  id_is_store,
  input  logic                  id_is_branch,
  input  logic                  id_br_ne,
  output logic                  br_taken,
  output param_defs::addr_t     br_target,
  output param_defs::data_t     ex_result,
  output param_defs::data_t     ex_store_data,
  output param_defs::reg_addr_t ex_rd,
  output logic                  ex_rd_we,
  output logic                  ex_is_load,
  output logic                  ex_is_store
);

  import param_defs::*;
  import instr_defs::*;

  data_t op_b;
  data_t alu_result;
  logic  equal;

  assign op_b = id_use_imm ? id_imm : id_rs2_val;

  always_comb begin
    case (id_alu_op)
      ALU_ADD:    alu_result = id_rs1_val + op_b;
      ALU_SUB:    alu_result = id_rs1_val - op_b;
      ALU_AND:    alu_result = id_rs1_val & op_b;
      ALU_OR:     alu_result = id_rs1_val | op_b;
      ALU_XOR:    alu_result = id_rs1_val ^ op_b;
      ALU_SLT:    alu_result = {{(DataWidth-1){1'b0}}, $signed(id_rs1_val) < $signed(op_b)};
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = id_rs1_val + op_b;
    endcase
  end

  // branches compare the two registers, never the immediate
  assign equal     = (id_rs1_val == id_rs2_val);
  assign br_taken  = id_is_branch && (id_br_ne ? !equal : equal);
  assign br_target = id_pc + id_imm;

  // EX/MEM control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_rd       <= '0;
      ex_rd_we    <= 1'b0;
      ex_is_load  <= 1'b0;
      ex_is_store <= 1'b0;
    end else if (!stall) begin
      ex_rd       <= id_rd;
      ex_rd_we    <= id_rd_we;
      ex_is_load  <= id_is_load;
      ex_is_store <= id_is_store;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_result     <= alu_result;  // also the load/store address
      ex_store_data <= id_rs2_val;
    end
  end

  // a taken branch must have flushed the slot behind it out of ID/EX
  br_flush_a : assert property (@(posedge clk) disable iff (!arst_n)
    br_taken && !stall |=> !id_is_branch);

endmodule : ex_stage

// File: rtl/reg_file.sv
// reg_file
// 32 x 32 register file, x0 reads zero, write data bypassed to same-cycle reads
`timescale 1ns/1ns

module reg_file (
  input  logic                  clk,
  input  logic                  arst_n,
  input  param_defs::reg_addr_t rs1_addr,
  input  param_defs::reg_addr_t rs2_addr,
  input  param_defs::reg_addr_t wb_rd,
  input  param_defs::data_t     wb_data,
  input  logic                  wb_we,
  output param_defs::data_t     rs1_data,
  output param_defs::data_t     rs2_data
);

  import param_defs::*;

  data_t regs [NumRegs];
  logic  wr_live;

  assign wr_live = wb_we && (wb_rd != '0);  // x0 writes dropped

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= DataZero;
      end
    end else if (wr_live) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // write-through, covers a consumer three slots behind
  assign rs1_data = (wr_live && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
  assign rs2_data = (wr_live && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule : reg_file

// File: rtl/id_stage.sv
// id_stage
// decodes the IF/ID word into ALU op, flags and immediate, and latches
// them with the register operands into ID/EX
`timescale 1ns/1ns

module id_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  stall,
  input  logic                  flush,
  input  param_defs::addr_t     if_pc,
  input  param_defs::instr_t    if_instr,
  input  param_defs::data_t     rs1_data,
  input  param_defs::data_t     rs2_data,
  output param_defs::reg_addr_t rs1_addr,
  output param_defs::reg_addr_t rs2_addr,
  output param_defs::addr_t     id_pc,
  output param_defs::data_t     id_imm,
  output param_defs::data_t     id_rs1_val,
  output param_defs::data_t     id_rs2_val,
  output instr_defs::alu_op_e   id_alu_op,
  output logic                  id_use_imm,
  output param_defs::reg_addr_t id_rd,
  output logic                  id_rd_we,
  output logic                  id_is_load,
  output logic                  id_is_store,
  output logic                  id_is_branch,
  output logic                  id_br_ne
);

  import param_defs::*;
  import instr_defs::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  data_t      imm_i;
  data_t      imm_s;
  data_t      imm_b;
  data_t      imm_u;
  data_t      imm;
  alu_op_e    alu_op_arith;
  logic       arith_ok;
  alu_op_e    alu_op;
  logic       use_imm;
  logic       rd_we;
  logic       is_load;
  logic       is_store;
  logic       is_branch;

  assign opcode   = opcode_e'(if_instr[6:0]);
  assign funct3   = if_instr[14:12];
  assign funct7   = if_instr[31:25];
  assign rs1_addr = if_instr[19:15];
  assign rs2_addr = if_instr[24:20];

  assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
  assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
  assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                  if_instr[11:8], 1'b0};
  assign imm_u = {if_instr[31:12], 12'b0};

  // arithmetic group, shared by register and immediate forms
  always_comb begin
    arith_ok     = 1'b1;
    alu_op_arith = ALU_ADD;
    case (funct3)
      F3_ADD_SUB: begin
        if (opcode == OP_REG && funct7 == F7_SUB) begin
          alu_op_arith = ALU_SUB;  // no subi in the ISA
        end
      end
      F3_SLT:  alu_op_arith = ALU_SLT;
      F3_XOR:  alu_op_arith = ALU_XOR;
      F3_OR:   alu_op_arith = ALU_OR;
      F3_AND:  alu_op_arith = ALU_AND;
      default: arith_ok = 1'b0;  // shifts and sltu not supported
    endcase
  end

  always_comb begin
    alu_op    = ALU_ADD;
    imm       = imm_i;
    use_imm   = 1'b0;
    rd_we     = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    case (opcode)
      OP_LUI: begin
        alu_op  = ALU_PASS_B;
        imm     = imm_u;
        use_imm = 1'b1;
        rd_we   = 1'b1;
      end
      OP_IMM: begin
        alu_op  = alu_op_arith;
        use_imm = 1'b1;
        rd_we   = arith_ok;
      end
      OP_REG: begin
        alu_op = alu_op_arith;
        rd_we  = arith_ok;
      end
      OP_LOAD: begin
        if (funct3 == F3_WORD) begin
          use_imm = 1'b1;  // address = rs1 + imm_i
          rd_we   = 1'b1;
          is_load = 1'b1;
        end
      end
      OP_STORE: begin
        if (funct3 == F3_WORD) begin
          imm      = imm_s;
          use_imm  = 1'b1;
          is_store = 1'b1;
        end
      end
      OP_BRANCH: begin
        if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
          imm       = imm_b;
          is_branch = 1'b1;
        end
      end
      default: ;  // unknown opcode falls out as a nop
    endcase
  end

  // ID/EX control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_alu_op    <= ALU_ADD;
      id_use_imm   <= 1'b0;
      id_rd        <= '0;
      id_rd_we     <= 1'b0;
      id_is_load   <= 1'b0;
      id_is_store  <= 1'b0;
      id_is_branch <= 1'b0;
      id_br_ne     <= 1'b0;
    end else if (!stall) begin
      id_alu_op    <= alu_op;
      id_use_imm   <= use_imm;
      id_rd        <= if_instr[11:7];
      id_rd_we     <= rd_we & ~flush;  // flushed slot becomes a nop
      id_is_load   <= is_load & ~flush;
      id_is_store  <= is_store & ~flush;
      id_is_branch <= is_branch & ~flush;
      id_br_ne     <= (funct3 == F3_BNE);
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      id_pc      <= if_pc;
      id_imm     <= imm;
      id_rs1_val <= rs1_data;
      id_rs2_val <= rs2_data;
    end
  end

endmodule : id_stage

// File: rtl/if_stage.sv
// if_stage
// program counter and IF/ID register, redirected by a taken branch
`timescale 1ns/1ns

module if_stage #(
  parameter param_defs::addr_t RESET_PC = param_defs::DefaultResetPc
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               stall,
  input  logic               flush,
  input  param_defs::addr_t  br_target,
  input  param_defs::instr_t imem_rd_data,
  output param_defs::addr_t  imem_addr,
  output param_defs::addr_t  if_pc,
  output param_defs::instr_t if_instr
);

  import param_defs::*;
  import instr_defs::*;

  addr_t pc_q;
  addr_t pc_next;

  assign pc_next   = flush ? br_target : pc_q + InstrBytes;
  assign imem_addr = pc_q;  // fetch every slot

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= RESET_PC;
    end else if (!stall) begin
      pc_q <= pc_next;
    end
  end

  // IF/ID register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      if_pc    <= RESET_PC;
      if_instr <= NOP_INSTR;
    end else if (!stall) begin
      if (flush) begin
        if_instr <= NOP_INSTR;  // squash the wrong-path fetch
      end else begin
        if_pc    <= pc_q;
        if_instr <= imem_rd_data;
      end
    end
  end

  // branch targets come from execute, so this also covers the immediate path
  pc_aligned_a : assert property (@(posedge clk) disable iff (!arst_n)
    pc_q[1:0] == 2'b00);

endmodule : if_stage

// File: rtl/instr_defs.sv
// instr_defs
// RV32I opcode and funct encodings for the supported subset, and the
// ALU operation set used between decode and execute
package instr_defs;

  // major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B  // lui, immediate straight through
  } alu_op_e;

  // arithmetic group funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // load/store kind, only full words are supported
  localparam logic [2:0] F3_WORD = 3'b010;

  // funct7 that turns add into sub
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage : instr_defs

// File: rtl/param_defs.sv
// param_defs
// data, address and register index widths shared by the pipeline,
// plus the values the core comes out of reset with
package param_defs;

  localparam int DataWidth    = 32;
  localparam int AddrWidth    = 32;
  localparam int InstrWidth   = 32;
  localparam int RegAddrWidth = 5;
  localparam int NumRegs      = 1 << RegAddrWidth;  // 32 architectural registers

  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [InstrWidth-1:0]   instr_t;
  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  // reset values
  localparam addr_t DefaultResetPc = '0;
  localparam data_t DataZero       = '0;

  // sequential fetch step
  localparam addr_t InstrBytes = 4;

endpackage : param_defs
